//--- phased_array.f
pa_cfg_pkg.sv
pa_cmd_pkg.sv
cmd_receiver.sv
silencer.sv
pulse_width_encoder.sv
pwm_out.sv
phased_array_top.sv
tb_phased_array_sva.sv
tb_phased_array.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_phased_array
FILELIST  ?= phased_array.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_phased_array.sv
`timescale 1ns/1ns

module tb_phased_array import pa_cfg_pkg::*, pa_cmd_pkg::*;;

  logic CLK, rst_n, req, ack;
  logic [2:0] opcode;
  logic [ch_w-1:0] ch;
  logic [15:0] data;
  logic [num_ch-1:0] pwm;

  logic [31:0] lfsr = 32'hc282;
  int ph, ack_d;
  int m_tint[num_ch], m_tph[num_ch], m_int[num_ch], m_ph[num_ch];
  int sh_r[num_ch], sh_f[num_ch], ac_r[num_ch], ac_f[num_ch];
  int m_sint, m_sph;
  logic [num_ch-1:0] exp_pwm;

  phased_array_top dut (.CLK(CLK), .rst_n(rst_n), .req(req), .opcode(opcode), .ch(ch),
    .data(data), .ack(ack), .pwm(pwm));

  always #2 CLK = ~CLK;

  function automatic int rand_bits(int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32 22 2 1.
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  task automatic check_val(string name, int got, int exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout while waiting for %s.", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // ############################################################
  // reference model, sampled on the falling edge.
  // ############################################################
  always @(negedge CLK) begin
    int k, up;
    if (!rst_n) begin
      ph = 0;
      ack_d = 0;
      exp_pwm = '0;
      m_sint = 255;
      m_sph = 255;
      m_tint = '{default: 0};
      m_tph = '{default: 0};
      m_int = '{default: 0};
      m_ph = '{default: 0};
      sh_r = '{default: 0};
      sh_f = '{default: 0};
      ac_r = '{default: 0};
      ac_f = '{default: 0};
    end else begin
      check_val("pwm", pwm, exp_pwm);
      for (int i = 0; i < num_ch; i++)  // high inside the half-open window.
        exp_pwm[i] = ((ph - ac_r[i]) & 511) < ((ac_f[i] - ac_r[i]) & 511);
      if (ph == period - 1) begin
        ac_r = sh_r;
        ac_f = sh_f;
      end
      if (ack && !ack_d) begin
        case (opcode)
          op_drive: begin
            m_tint[ch] = data[15:8];
            m_tph[ch] = data[7:0];
          end
          op_step_int: m_sint = data[7:0];
          op_step_phase: m_sph = data[7:0];
          default: ;
        endcase
      end
      ack_d = ack;
      k = (ph == period - 1) ? 0 : ph + 1;
      if (k < num_ch) begin
        if (m_tint[k] >= m_int[k])
          m_int[k] = (m_tint[k] - m_int[k] > m_sint) ? m_int[k] + m_sint : m_tint[k];
        else
          m_int[k] = (m_int[k] - m_tint[k] > m_sint) ? m_int[k] - m_sint : m_tint[k];
        up = (m_tph[k] - m_ph[k]) & 255;
        if (up <= 128) m_ph[k] = (up > m_sph) ? (m_ph[k] + m_sph) & 255 : m_tph[k];
        else m_ph[k] = (256 - up > m_sph) ? (m_ph[k] - m_sph) & 255 : m_tph[k];
        sh_r[k] = (2 * m_ph[k] - m_int[k]) & 511;
        sh_f[k] = (sh_r[k] + 2 * m_int[k]) & 511;
      end
      ph = (ph + 1) % period;  // follows the counter, which starts at 0.
    end
  end

  task automatic send_cmd(int op, int c, int d);
    int t;
    @(posedge CLK);
    #1;
    check_val("ack", ack, 0);
    opcode = 3'(op);
    ch = ch_w'(c);
    data = 16'(d);
    req = 1'b1;
    t = 0;
    do begin
      @(posedge CLK);
      #1 t++;
    end while (!ack && t < 20);
    if (!ack) timeout_fail("ack to rise");
    req = 1'b0;
    t = 0;
    do begin
      @(posedge CLK);
      #1 t++;
    end while (ack && t < 20);
    if (ack) timeout_fail("ack to fall");
  endtask

  task automatic wait_periods(int n);
    int t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      do begin
        @(posedge CLK);
        #1 t++;
      end while (ph != period - 1 && t < 2 * period);
      if (ph != period - 1) timeout_fail("the period update");
    end
  endtask

  initial begin
    int p;
    CLK = 0;
    rst_n = 0;
    req = 0;
    opcode = '0;
    ch = '0;
    data = '0;
    repeat (5) @(posedge CLK);
    #1 rst_n = 1;
    for (int i = 0; i < num_ch; i++) send_cmd(op_drive, i, rand_bits(16));  // jump.
    wait_periods(3);
    send_cmd(op_step_int, 0, 1 + rand_bits(3));  // slow intensity slew.
    for (int i = 0; i < num_ch; i++) send_cmd(op_drive, i, rand_bits(16));
    wait_periods(45);
    send_cmd(op_step_int, 0, 255);
    for (int i = 0; i < num_ch; i++) begin
      p = (i % 2) ? 8'hc0 | rand_bits(6) : rand_bits(5);
      send_cmd(op_drive, i, {8'(20 + rand_bits(6)), 8'(p)});
    end
    wait_periods(3);
    send_cmd(op_step_phase, 0, 1 + rand_bits(2));  // walk across the wrap point.
    for (int i = 0; i < num_ch; i++) begin
      p = (m_tph[i] + ((i % 2) ? 40 + rand_bits(5) : -40)) & 255;
      send_cmd(op_drive, i, {8'(m_tint[i]), 8'(p)});
    end
    wait_periods(25);
    send_cmd(op_nop, rand_bits(2), rand_bits(16));
    for (int op = 4; op < 8; op++) send_cmd(op, rand_bits(2), rand_bits(16));
    wait_periods(3);
    send_cmd(op_step_phase, 0, 255);
    send_cmd(op_drive, 2, {8'd0, 8'(rand_bits(8))});
    wait_periods(4);
    $display("Test passed");
    $finish;
  end

endmodule

//--- tb_phased_array_sva.sv
`timescale 1ns/1ns

module tb_phased_array_sva (
  input logic CLK,
  input logic rst_n,
  input logic req,
  input logic ack,
  input logic update,
  input logic s_valid
);

  // ##########################################################
  // four-phase handshake.
  // ##########################################################
  ack_rise_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(ack) |-> $past(req)) else $error("ack rose while req was low.");

  ack_fall_needs_no_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(ack) |-> !$past(req)) else $error("ack fell while req was high.");

  // one scan of four channels per update.
  scan_length: assert property (@(posedge CLK) disable iff (!rst_n)
    update |=> s_valid [*4] ##1 !s_valid) else $error("scan length is not four.");

endmodule

bind phased_array_top tb_phased_array_sva sva (
  .CLK(CLK), .rst_n(rst_n), .req(req), .ack(ack), .update(update), .s_valid(s_valid)
);

//--- phased_array_top.sv
`timescale 1ns/1ns

module phased_array_top import pa_cfg_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic [2:0]            opcode,
  input  logic [ch_w-1:0]       ch,
  input  logic [amp_w+ph_w-1:0] data,
  output logic                  ack,
  output logic [num_ch-1:0]     pwm
);

  logic [num_ch*amp_w-1:0] tgt_int;
  logic [num_ch*ph_w-1:0]  tgt_ph;
  logic [amp_w-1:0]        step_int;
  logic [ph_w-1:0]         step_ph;
  logic                    update;

  logic                    s_valid;
  logic [ch_w-1:0]         s_ch;
  logic [amp_w-1:0]        s_int;
  logic [ph_w-1:0]         s_ph;

  logic                    e_valid;
  logic [ch_w-1:0]         e_ch;
  logic [cnt_w-1:0]        e_rise, e_fall;

  cmd_receiver u_cmd (
    .CLK(CLK), .rst_n(rst_n), .req(req), .opcode(opcode), .ch(ch), .data(data),
    .ack(ack), .tgt_int(tgt_int), .tgt_ph(tgt_ph),
    .step_int(step_int), .step_ph(step_ph)
  );

  // scan runs once per carrier period, kicked by the pwm counter.
  silencer u_sil (
    .CLK(CLK), .rst_n(rst_n), .update(update),
    .tgt_int(tgt_int), .tgt_ph(tgt_ph), .step_int(step_int), .step_ph(step_ph),
    .s_valid(s_valid), .s_ch(s_ch), .s_int(s_int), .s_ph(s_ph)
  );

  pulse_width_encoder u_enc (
    .CLK(CLK), .rst_n(rst_n),
    .s_valid(s_valid), .s_ch(s_ch), .s_int(s_int), .s_ph(s_ph),
    .e_valid(e_valid), .e_ch(e_ch), .e_rise(e_rise), .e_fall(e_fall)
  );

  pwm_out u_pwm (
    .CLK(CLK), .rst_n(rst_n),
    .e_valid(e_valid), .e_ch(e_ch), .e_rise(e_rise), .e_fall(e_fall),
    .update(update), .pwm(pwm)
  );

endmodule

//--- pwm_out.sv
`timescale 1ns/1ns

module pwm_out import pa_cfg_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              e_valid,
  input  logic [ch_w-1:0]   e_ch,
  input  logic [cnt_w-1:0]  e_rise,
  input  logic [cnt_w-1:0]  e_fall,
  output logic              update,
  output logic [num_ch-1:0] pwm
);

  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] sh_rise [num_ch];
  logic [cnt_w-1:0] sh_fall [num_ch];
  logic [cnt_w-1:0] act_rise [num_ch];
  logic [cnt_w-1:0] act_fall [num_ch];
  logic [num_ch-1:0] in_win;

  assign update = (cnt == cnt_w'(period - 1));  // last cycle of the period.

  // ##########################################################
  // window compare, rise > fall means the pulse wraps.
  // ##########################################################
  always_comb begin
    for (int i = 0; i < num_ch; i++) begin
      if (act_rise[i] <= act_fall[i]) begin
        in_win[i] = (cnt >= act_rise[i]) && (cnt < act_fall[i]);
      end else begin
        in_win[i] = (cnt >= act_rise[i]) || (cnt < act_fall[i]);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cnt <= '0;
      pwm <= '0;
      for (int i = 0; i < num_ch; i++) begin
        sh_rise[i]  <= '0;
        sh_fall[i]  <= '0;
        act_rise[i] <= '0;  // empty windows until the first scan lands.
        act_fall[i] <= '0;
      end
    end else begin
      cnt <= cnt + cnt_w'(1);  // the period fills the counter, so it wraps by itself.
      pwm <= in_win;
      if (e_valid) begin
        sh_rise[e_ch] <= e_rise;
        sh_fall[e_ch] <= e_fall;
      end
      if (update) begin
        act_rise <= sh_rise;
        act_fall <= sh_fall;
      end
    end
  end

endmodule

//--- pulse_width_encoder.sv
`timescale 1ns/1ns

module pulse_width_encoder import pa_cfg_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              s_valid,
  input  logic [ch_w-1:0]   s_ch,
  input  logic [amp_w-1:0]  s_int,
  input  logic [ph_w-1:0]   s_ph,
  output logic              e_valid,
  output logic [ch_w-1:0]   e_ch,
  output logic [cnt_w-1:0]  e_rise,
  output logic [cnt_w-1:0]  e_fall
);

  logic [cnt_w-1:0] width;
  logic [cnt_w-1:0] rise;
  logic [cnt_w-1:0] fall;

  // linear duty rule, the pulse is centred on twice the phase.
  assign width = {s_int, 1'b0};
  assign rise  = {s_ph, 1'b0} - cnt_w'(s_int);  // wraps modulo the period.
  assign fall  = rise + width;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      e_valid <= 1'b0;
    end else begin
      e_valid <= s_valid;
    end
  end

  always_ff @(posedge CLK) begin
    e_ch   <= s_ch;  // the index rides along with the result.
    e_rise <= rise;
    e_fall <= fall;
  end

endmodule

//--- silencer.sv
`timescale 1ns/1ns

module silencer import pa_cfg_pkg::*, pa_cmd_pkg::*; (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     update,
  input  logic [num_ch*amp_w-1:0]  tgt_int,
  input  logic [num_ch*ph_w-1:0]   tgt_ph,
  input  logic [amp_w-1:0]         step_int,
  input  logic [ph_w-1:0]          step_ph,
  output logic                     s_valid,
  output logic [ch_w-1:0]          s_ch,
  output logic [amp_w-1:0]         s_int,
  output logic [ph_w-1:0]          s_ph
);

  scan_state_e     state;
  logic [ch_w-1:0] idx;
  logic            active;

  logic [amp_w-1:0] cur_int [num_ch];
  logic [ph_w-1:0]  cur_ph [num_ch];

  logic [amp_w-1:0] c_int, t_int, d_int, n_int;
  logic [ph_w-1:0]  c_ph, t_ph, d_up, d_dn, n_ph;

  // channel 0 is handled in the update cycle itself, the rest follow back to back.
  assign active = update || (state == sc_run);

  assign c_int = cur_int[idx];
  assign t_int = tgt_int[idx*amp_w +: amp_w];
  assign c_ph  = cur_ph[idx];
  assign t_ph  = tgt_ph[idx*ph_w +: ph_w];
  assign d_up  = t_ph - c_ph;  // distances wrap modulo 256.
  assign d_dn  = c_ph - t_ph;

  // ##########################################################
  // bounded step toward the target.
  // ##########################################################
  always_comb begin
    if (t_int >= c_int) begin
      d_int = t_int - c_int;
      n_int = (d_int > step_int) ? c_int + step_int : t_int;
    end else begin
      d_int = c_int - t_int;
      n_int = (d_int > step_int) ? c_int - step_int : t_int;
    end
    // the shorter way round; half a turn counts as upward.
    if (d_up <= ph_w'(1 << (ph_w - 1))) begin
      n_ph = (d_up > step_ph) ? c_ph + step_ph : t_ph;
    end else begin
      n_ph = (d_dn > step_ph) ? c_ph - step_ph : t_ph;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state   <= sc_idle;
      idx     <= '0;
      s_valid <= 1'b0;
      for (int i = 0; i < num_ch; i++) begin
        cur_int[i] <= '0;
        cur_ph[i]  <= '0;
      end
    end else begin
      s_valid <= active;
      if (active) begin
        cur_int[idx] <= n_int;
        cur_ph[idx]  <= n_ph;
        idx          <= idx + ch_w'(1);
        state        <= (idx == ch_w'(num_ch - 1)) ? sc_idle : sc_run;
      end
    end
  end

  always_ff @(posedge CLK) begin
    s_ch  <= idx;
    s_int <= n_int;
    s_ph  <= n_ph;
  end

endmodule

//--- cmd_receiver.sv
`timescale 1ns/1ns

module cmd_receiver import pa_cfg_pkg::*, pa_cmd_pkg::*; (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     req,
  input  logic [2:0]               opcode,
  input  logic [ch_w-1:0]          ch,
  input  logic [amp_w+ph_w-1:0]    data,
  output logic                     ack,
  output logic [num_ch*amp_w-1:0]  tgt_int,
  output logic [num_ch*ph_w-1:0]   tgt_ph,
  output logic [amp_w-1:0]         step_int,
  output logic [ph_w-1:0]          step_ph
);

  hs_state_e state;
  opcode_e   op;

  assign op  = opcode_e'(opcode);
  assign ack = (state == hs_ack);  // ack is the state register itself.

  // ##########################################################
  // four-phase handshake and command decode.
  // ##########################################################
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= hs_idle;
      tgt_int  <= '0;
      tgt_ph   <= '0;
      step_int <= '1;  // full steps, so the first scan jumps to target.
      step_ph  <= '1;
    end else begin
      case (state)
        hs_idle: begin
          // a command is taken only here, once per req pulse.
          if (req) begin
            state <= hs_ack;
            case (op)
              op_drive: begin
                tgt_int[ch*amp_w +: amp_w] <= data[ph_w +: amp_w];
                tgt_ph[ch*ph_w +: ph_w]    <= data[ph_w-1:0];
              end
              op_step_int: begin
                step_int <= data[amp_w-1:0];
              end
              op_step_phase: begin
                step_ph <= data[ph_w-1:0];
              end
              default: begin
                // op_nop and the spare codes only complete the handshake.
              end
            endcase
          end
        end
        hs_ack: begin
          if (!req) begin
            state <= hs_idle;  // ack drops on this edge.
          end
        end
        default: begin
          state <= hs_idle;
        end
      endcase
    end
  end

endmodule

//--- pa_cmd_pkg.sv
package pa_cmd_pkg;

  // host command codes, the unlisted ones are accepted and ignored.
  typedef enum logic [2:0] {
    op_nop        = 3'd0,
    op_drive      = 3'd1,
    op_step_int   = 3'd2,
    op_step_phase = 3'd3
  } opcode_e;

  typedef enum logic {hs_idle, hs_ack} hs_state_e;

  typedef enum logic {sc_idle, sc_run} scan_state_e;

endpackage

//--- pa_cfg_pkg.sv
package pa_cfg_pkg;

  // ##########################################################
  // array geometry.
  // ##########################################################
  localparam int num_ch = 4;     // transducer channels.
  localparam int ch_w   = 2;     // channel index width.

  // ##########################################################
  // carrier timing and value widths.
  // ##########################################################
  localparam int period = 512;   // carrier period in clock cycles.
  localparam int cnt_w  = 9;     // period counter and edge time width.
  localparam int amp_w  = 8;
  localparam int ph_w   = 8;     // one phase step is two counter cycles.

endpackage
